/* verilog/merge_defs.svh */
`ifndef MERGE_DEFS_SVH
`define MERGE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream merger build constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Width of one stream byte on every data port
`define MERGE_DATA_W 8

// Entries held by each channel FIFO
// Kept off a power of two on purpose, so the index wrap logic is exercised
`define MERGE_FIFO_DEPTH 6

`endif

/* verilog/merge_pkg.sv */
`default_nettype none

`include "merge_defs.svh"

package merge_pkg;

  // Tag carried with each output byte to name its source channel
  typedef enum logic {
    SRC_A = 1'b0,
    SRC_B = 1'b1
  } src_e;

  // Merger state, the channel that wins when both FIFOs hold data
  typedef enum logic {
    PRIO_A = 1'b0,
    PRIO_B = 1'b1
  } prio_e;

endpackage

`default_nettype wire

/* verilog/stream_fifo.sv */
`default_nettype none

`include "merge_defs.svh"

module stream_fifo #(
  parameter int DATA_W = `MERGE_DATA_W,
  parameter int DEPTH  = `MERGE_FIFO_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              wr_valid_i,
  input  logic [DATA_W-1:0] data_i,

  input  logic              rd_valid_i,
  output logic [DATA_W-1:0] data_o,

  output logic              empty_o,
  output logic              full_o,
  output logic              overflow_o
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage and pointers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [DATA_W-1:0] mem [0:DEPTH-1];
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;
  logic [CNT_W-1:0]  count;

  logic              wr_ok;
  logic              rd_ok;
  logic [IDX_W-1:0]  wr_idx_nxt;
  logic [IDX_W-1:0]  rd_idx_nxt;

  // Status is taken from the count, so it follows the edge that moved it
  assign empty_o = (count == '0);
  assign full_o  = (count == FULL_CNT);

  // A full FIFO refuses the write even when a pop happens at the same edge
  assign wr_ok = wr_valid_i & ~full_o;
  assign rd_ok = rd_valid_i & ~empty_o;

  // Each index wraps back to zero at the last entry
  assign wr_idx_nxt = (wr_idx == LAST_IDX) ? '0 : wr_idx + 1'b1;
  assign rd_idx_nxt = (rd_idx == LAST_IDX) ? '0 : rd_idx + 1'b1;

  // Oldest entry is always presented on the output
  assign data_o = mem[rd_idx];

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_idx] <= data_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_idx <= '0;
      rd_idx <= '0;
    end else begin
      if (wr_ok) begin
        wr_idx <= wr_idx_nxt;
      end
      if (rd_ok) begin
        rd_idx <= rd_idx_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // One-cycle pulse for every write lost to a full FIFO
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      overflow_o <= 1'b0;
    end else begin
      overflow_o <= wr_valid_i & full_o;
    end
  end

endmodule

`default_nettype wire

/* verilog/rr_merger.sv */
`default_nettype none

`include "merge_defs.svh"

module rr_merger (
  input  logic                     clk,
  input  logic                     rst_n,

  // Channel A FIFO head
  input  logic                     a_empty_i,
  input  logic [`MERGE_DATA_W-1:0] a_data_i,

  // Channel B FIFO head
  input  logic                     b_empty_i,
  input  logic [`MERGE_DATA_W-1:0] b_data_i,

  // Pop strobes back to the FIFOs
  output logic                     rd_a_o,
  output logic                     rd_b_o,

  // Merged output stream
  output logic                     out_valid_o,
  output logic [`MERGE_DATA_W-1:0] out_data_o,
  output merge_pkg::src_e          out_src_o
);

  import merge_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbitration
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  prio_e                    prio_q;
  prio_e                    prio_d;

  logic                     pick_a;
  logic                     pick_b;
  logic                     pop_any;
  logic [`MERGE_DATA_W-1:0] pick_data;
  src_e                     pick_src;

  // A lone non-empty FIFO is always served
  // With both non-empty the priority state breaks the tie
  always_comb begin
    pick_a = ~a_empty_i & (b_empty_i | (prio_q == PRIO_A));
    pick_b = ~b_empty_i & (a_empty_i | (prio_q == PRIO_B));
  end

  assign pop_any = pick_a | pick_b;

  // The served channel loses priority to the other one
  always_comb begin
    if (pick_a) begin
      prio_d = PRIO_B;
    end else if (pick_b) begin
      prio_d = PRIO_A;
    end else begin
      prio_d = prio_q;
    end
  end

  // Head byte and tag of the winner, meaningful only when pop_any is set
  always_comb begin
    if (pick_a) begin
      pick_data = a_data_i;
      pick_src  = SRC_A;
    end else begin
      pick_data = b_data_i;
      pick_src  = SRC_B;
    end
  end

  assign rd_a_o = pick_a;
  assign rd_b_o = pick_b;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registered output
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prio_q      <= PRIO_A;
      out_valid_o <= 1'b0;
    end else begin
      prio_q      <= prio_d;
      out_valid_o <= pop_any;
    end
  end

  // Byte and tag are captured at the same edge as the pop
  always_ff @(posedge clk) begin
    if (pop_any) begin
      out_data_o <= pick_data;
      out_src_o  <= pick_src;
    end
  end

endmodule

`default_nettype wire

/* verilog/dual_stream_merge.sv */
`default_nettype none

`include "merge_defs.svh"

module dual_stream_merge (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     in_a_valid_i,
  input  logic [`MERGE_DATA_W-1:0] in_a_data_i,

  input  logic                     in_b_valid_i,
  input  logic [`MERGE_DATA_W-1:0] in_b_data_i,

  output logic                     out_valid_o,
  output logic [`MERGE_DATA_W-1:0] out_data_o,
  output merge_pkg::src_e          out_src_o,

  output logic                     overflow_a_o,
  output logic                     overflow_b_o
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FIFO to merger wiring
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic                     a_empty;
  logic [`MERGE_DATA_W-1:0] a_head;
  logic                     rd_a;

  logic                     b_empty;
  logic [`MERGE_DATA_W-1:0] b_head;
  logic                     rd_b;

  // Channel A buffer, full flag is only needed inside the FIFO
  stream_fifo u_fifo_a (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid_i (in_a_valid_i),
    .data_i     (in_a_data_i),
    .rd_valid_i (rd_a),
    .data_o     (a_head),
    .empty_o    (a_empty),
    .full_o     (),
    .overflow_o (overflow_a_o)
  );

  stream_fifo u_fifo_b (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid_i (in_b_valid_i),
    .data_i     (in_b_data_i),
    .rd_valid_i (rd_b),
    .data_o     (b_head),
    .empty_o    (b_empty),
    .full_o     (),
    .overflow_o (overflow_b_o)
  );

  // Round-robin drain of both buffers into one tagged stream
  rr_merger u_merger (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_empty_i   (a_empty),
    .a_data_i    (a_head),
    .b_empty_i   (b_empty),
    .b_data_i    (b_head),
    .rd_a_o      (rd_a),
    .rd_b_o      (rd_b),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_src_o   (out_src_o)
  );

endmodule

`default_nettype wire

/* bench/dual_stream_merge_checker.sv */
`default_nettype none

module dual_stream_merge_checker (
  input  logic clk,
  input  logic rst_n,
  input  logic a_empty_i,
  input  logic b_empty_i,
  input  logic rd_a_i,
  input  logic rd_b_i,
  input  logic out_valid_i
);

  // Number of assertion failures so far, read from the testbench
  int unsigned fail_count = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Merger handshake properties
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A pop only ever goes to a FIFO that holds data
  pop_a_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
    rd_a_i |-> !a_empty_i)
    else begin
      fail_count++;
      $error("Pop issued to empty FIFO A");
    end

  pop_b_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
    rd_b_i |-> !b_empty_i)
    else begin
      fail_count++;
      $error("Pop issued to empty FIFO B");
    end

  pop_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_a_i && rd_b_i))
    else begin
      fail_count++;
      $error("Both FIFOs popped in the same cycle");
    end

  // The output strobe is exactly the pop delayed by one cycle
  valid_follows_pop: assert property (@(posedge clk) disable iff (!rst_n)
    1'b1 |=> (out_valid_i == $past(rd_a_i || rd_b_i)))
    else begin
      fail_count++;
      $error("out_valid_o does not follow the pop by one cycle");
    end

endmodule

bind rr_merger dual_stream_merge_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .a_empty_i   (a_empty_i),
  .b_empty_i   (b_empty_i),
  .rd_a_i      (rd_a_o),
  .rd_b_i      (rd_b_o),
  .out_valid_i (out_valid_o)
);

`default_nettype wire

/* bench/dual_stream_merge_tb.sv */
`default_nettype none

`include "merge_defs.svh"

module dual_stream_merge_tb;

  import merge_pkg::*;

  localparam int DEPTH = `MERGE_FIFO_DEPTH;
  localparam int W     = `MERGE_DATA_W;

  logic         clk;
  logic         rst_n;
  logic         in_a_valid;
  logic [W-1:0] in_a_data;
  logic         in_b_valid;
  logic [W-1:0] in_b_data;
  logic         out_valid;
  logic [W-1:0] out_data;
  src_e         out_src;
  logic         overflow_a;
  logic         overflow_b;

  // Reference model state with two bounded queues and the priority
  logic [W-1:0] qa[$];
  logic [W-1:0] qb[$];
  prio_e        model_prio;
  logic         exp_valid;
  logic [W-1:0] exp_data;
  src_e         exp_src;
  logic         exp_ovf_a;
  logic         exp_ovf_b;
  int unsigned  ovf_a_cnt;
  int unsigned  ovf_b_cnt;
  logic [31:0]  rng_state;

  dual_stream_merge i_dual_stream_merge (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_a_valid_i (in_a_valid),
    .in_a_data_i  (in_a_data),
    .in_b_valid_i (in_b_valid),
    .in_b_data_i  (in_b_data),
    .out_valid_o  (out_valid),
    .out_data_o   (out_data),
    .out_src_o    (out_src),
    .overflow_a_o (overflow_a),
    .overflow_b_o (overflow_b)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      fail_run();
    end
  endtask

  // Inputs change just after an edge and are sampled at the next one
  task automatic drive_cycle(input logic va, input logic [W-1:0] da,
                             input logic vb, input logic [W-1:0] db);
    @(posedge clk);
    in_a_valid <= va;
    in_a_data  <= da;
    in_b_valid <= vb;
    in_b_data  <= db;
  endtask

  task automatic compare_outputs();
    if (i_dual_stream_merge.u_merger.u_checker.fail_count != 0) begin
      $display("A handshake assertion in the merger checker failed");
      fail_run();
    end
    check_equal(32'(out_valid), 32'(exp_valid), "out_valid_o");
    check_equal(32'(overflow_a), 32'(exp_ovf_a), "overflow_a_o");
    check_equal(32'(overflow_b), 32'(exp_ovf_b), "overflow_b_o");
    if (exp_valid) begin
      check_equal(32'(out_data), 32'(exp_data), "out_data_o");
      check_equal(32'(out_src), 32'(exp_src), "out_src_o");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Cycle model that checks the outputs of the previous edge first
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin : ref_model
    logic full_a;
    logic full_b;
    logic take_a;
    logic take_b;
    if (!rst_n) begin
      qa.delete();
      qb.delete();
      model_prio = PRIO_A;
      exp_valid  = 1'b0;
      exp_ovf_a  = 1'b0;
      exp_ovf_b  = 1'b0;
    end else begin
      compare_outputs();
      // Pulses seen on the DUT ports, counted for the overflow test
      ovf_a_cnt += overflow_a;
      ovf_b_cnt += overflow_b;
      // Fullness is judged before the pop of this edge
      full_a = (qa.size() == DEPTH);
      full_b = (qb.size() == DEPTH);
      take_a = (qa.size() != 0) && ((qb.size() == 0) || (model_prio == PRIO_A));
      take_b = (qb.size() != 0) && !take_a;
      exp_valid = take_a || take_b;
      if (take_a) begin
        exp_data   = qa.pop_front();
        exp_src    = SRC_A;
        model_prio = PRIO_B;
      end else if (take_b) begin
        exp_data   = qb.pop_front();
        exp_src    = SRC_B;
        model_prio = PRIO_A;
      end
      exp_ovf_a = in_a_valid && full_a;
      exp_ovf_b = in_b_valid && full_b;
      if (in_a_valid && !full_a) begin
        qa.push_back(in_a_data);
      end
      if (in_b_valid && !full_b) begin
        qb.push_back(in_b_data);
      end
    end
  end

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    do begin
      drive_cycle(1'b0, '0, 1'b0, '0);
      @(negedge clk);
      cycles++;
    end while ((qa.size() != 0 || qb.size() != 0) && cycles < limit);
    if (qa.size() != 0 || qb.size() != 0) begin
      $display("Timeout, the FIFOs did not drain within %0d cycles", limit);
      fail_run();
    end
    // Lets the model compare the last popped byte and the idle cycle after it
    repeat (2) drive_cycle(1'b0, '0, 1'b0, '0);
    @(negedge clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_state();
    repeat (5) begin
      drive_cycle(1'b0, '0, 1'b0, '0);
      @(negedge clk);
      check_equal(32'(out_valid), 32'd0, "out_valid_o after reset");
      check_equal(32'({overflow_a, overflow_b}), 32'd0, "overflow after reset");
    end
  endtask

  // The byte is popped one edge after its write edge and then sits on the output
  task automatic send_single(input src_e ch, input logic [W-1:0] data);
    drive_cycle(ch == SRC_A, data, ch == SRC_B, data);
    drive_cycle(1'b0, '0, 1'b0, '0);
    drive_cycle(1'b0, '0, 1'b0, '0);
    @(negedge clk);
    check_equal(32'(out_valid), 32'd1, "out_valid_o one cycle after write");
    check_equal(32'(out_data), 32'(data), "pass-through byte");
    check_equal(32'(out_src), 32'(ch), "pass-through tag");
  endtask

  task automatic test_single_channel();
    for (int i = 0; i < 8; i++) begin
      rng_state = lcg_step(rng_state);
      send_single((i < 4) ? SRC_A : SRC_B, rng_state[31:24]);
    end
  endtask

  task automatic test_round_robin();
    for (int i = 0; i < DEPTH; i++) begin
      rng_state = lcg_step(rng_state);
      drive_cycle(1'b1, rng_state[31:24], 1'b1, rng_state[23:16]);
    end
    wait_drain(4 * DEPTH);
  endtask

  task automatic test_overflow();
    int unsigned base_a;
    int unsigned base_b;
    base_a = ovf_a_cnt;
    base_b = ovf_b_cnt;
    for (int i = 0; i < 3 * DEPTH; i++) begin
      drive_cycle(1'b1, W'(8'h10 + i), 1'b1, W'(8'h80 + i));
    end
    wait_drain(4 * DEPTH);
    check_equal(32'(ovf_a_cnt > base_a), 32'd1, "overflow pulses on channel A");
    check_equal(32'(ovf_b_cnt > base_b), 32'd1, "overflow pulses on channel B");
  endtask

  task automatic test_random_traffic();
    for (int i = 0; i < 400; i++) begin
      rng_state = lcg_step(rng_state);
      drive_cycle(rng_state[31:30] != 2'b00, rng_state[23:16],
                  rng_state[29], rng_state[15:8]);
    end
    wait_drain(8 * DEPTH);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_a_valid = 1'b0;
    in_a_data  = '0;
    in_b_valid = 1'b0;
    in_b_data  = '0;
    ovf_a_cnt  = 0;
    ovf_b_cnt  = 0;
    rng_state  = 32'h176e;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_single_channel();
    test_round_robin();
    test_overflow();
    test_random_traffic();
    if (i_dual_stream_merge.u_merger.u_checker.fail_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("A handshake assertion in the merger checker failed");
      fail_run();
    end
  end

endmodule

`default_nettype wire

/* dual_stream_merge.f */
+incdir+verilog
verilog/merge_pkg.sv
verilog/stream_fifo.sv
verilog/rr_merger.sv
verilog/dual_stream_merge.sv
bench/dual_stream_merge_checker.sv
bench/dual_stream_merge_tb.sv
